//--- hdl/dcu_bit_decoder.sv
module dcu_bit_decoder (
    input  logic                          CLK,
    input  logic                          rst_n,
    input  logic                          dcu_init,
    input  dcu_pkg::dcu_mode_e            dcu_init_mode,
    input  logic                          bit_req,
    input  logic [dcu_pkg::DCU_CTX_W-1:0] req_ctx,
    input  logic [7:0]                    fetch_byte,
    input  logic                          fetch_valid,
    input  logic                          preread_done,
    output logic                          fetch_take,
    output logic                          bit_done,
    output logic                          bit_val
);
    import dcu_pkg::*;

    dcu_dec_state_e         state;
    dcu_ctx_t               ctx_mem [DCU_NUM_CTX];
    logic [DCU_CTX_W-1:0]   ctx_idx;
    logic [DCU_RANGE_W-1:0] range_q;
    logic [15:0]            window;
    logic [2:0]             shift_cnt;
    logic [1:0]             fill_cnt;
    logic                   active;

    dcu_ctx_t               cur_ctx;
    dcu_prob_entry_t        entry;
    logic [DCU_RANGE_W-1:0] lps_off;
    logic [DCU_RANGE_W-1:0] range_dec;
    logic                   is_mps;
    logic                   renorm;
    logic                   need_byte;

    ////////////////////////////////////////////////////////////////////////////
    // Symbol decision

    assign cur_ctx = ctx_mem[ctx_idx];

    dcu_prob_table u_prob_table (
        .model (cur_ctx.model),
        .entry (entry)
    );

    assign lps_off   = range_q - DCU_RANGE_W'(entry.prob);
    assign is_mps    = DCU_RANGE_W'(window[15:8]) < lps_off;
    assign range_dec = is_mps ? lps_off : range_q - lps_off;
    assign renorm    = range_q < DCU_RANGE_W'(DCU_RANGE_HALF);
    // Eighth shift since the last refill pulls in a new low byte
    assign need_byte = shift_cnt == 3'd7;
    assign bit_done  = state == DONE;

    always_comb begin
        fetch_take = 1'b0;
        if (state == DECODE && fill_cnt != 2'd0) begin
            fetch_take = preread_done && fetch_valid;
        end else if (state == RENORM && renorm && need_byte) begin
            fetch_take = fetch_valid;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Decode and renormalise FSM

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            active    <= 1'b0;
            ctx_idx   <= '0;
            range_q   <= DCU_RANGE_W'(DCU_RANGE_INIT);
            window    <= '0;
            shift_cnt <= '0;
            fill_cnt  <= '0;
            bit_val   <= 1'b0;
            for (int i = 0; i < DCU_NUM_CTX; i++) begin
                ctx_mem[i] <= '0;
            end
        end else if (dcu_init) begin
            state     <= IDLE;
            active    <= dcu_init_mode != MODE_4BPP;
            range_q   <= DCU_RANGE_W'(DCU_RANGE_INIT);
            shift_cnt <= '0;
            fill_cnt  <= 2'd2;
            for (int i = 0; i < DCU_NUM_CTX; i++) begin
                ctx_mem[i] <= '0;
            end
        end else begin
            case (state)
                IDLE: begin
                    if (active && bit_req) begin
                        ctx_idx <= req_ctx;
                        state   <= DECODE;
                    end
                end
                DECODE: begin
                    if (fill_cnt != 2'd0) begin
                        // Window still loading its first two bytes
                        if (fetch_take) begin
                            window   <= {window[7:0], fetch_byte};
                            fill_cnt <= fill_cnt - 2'd1;
                        end
                    end else begin
                        range_q <= range_dec;
                        bit_val <= ~is_mps ^ cur_ctx.swap;
                        if (!is_mps) begin
                            window[15:8] <= window[15:8] - lps_off[7:0];
                        end
                        if (range_dec < DCU_RANGE_W'(DCU_RANGE_HALF)) begin
                            if (is_mps) begin
                                ctx_mem[ctx_idx].model <= entry.next_mps;
                            end else begin
                                ctx_mem[ctx_idx].model <= entry.next_lps;
                                ctx_mem[ctx_idx].swap  <= cur_ctx.swap ^ entry.invert;
                            end
                        end
                        state <= RENORM;
                    end
                end
                RENORM: begin
                    if (!renorm) begin
                        state <= DONE;
                    end else if (!need_byte || fetch_valid) begin
                        range_q   <= range_q << 1;
                        window    <= {window[14:0], 1'b0};
                        shift_cnt <= shift_cnt + 3'd1;
                        if (need_byte) begin
                            window[7:0] <= fetch_byte;
                        end
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

//--- hdl/dcu_pixel_packer.sv
module dcu_pixel_packer (
    input  logic                           CLK,
    input  logic                           rst_n,
    input  logic                           dcu_init,
    input  dcu_pkg::dcu_mode_e             dcu_init_mode,
    input  logic                           bit_done,
    input  logic                           bit_val,
    input  logic                           ob_wait,
    output logic                           bit_req,
    output logic [dcu_pkg::DCU_CTX_W-1:0]  req_ctx,
    output logic                           ob_wr,
    output logic [dcu_pkg::DCU_WORD_W-1:0] ob_data
);
    import dcu_pkg::*;

    logic                          active;
    dcu_mode_e                     mode;
    logic                          busy;
    logic                          word_pending;
    logic [$clog2(DCU_WORD_W)-1:0] bit_cnt;
    logic [3:0]                    history;
    logic [1:0]                    prev_pix;
    logic                          p0_bit;
    logic [DCU_WORD_W-1:0]         planes;
    logic                          plane;

    ////////////////////////////////////////////////////////////////////////////
    // Context selection

    // 2BPP alternates plane 0 and plane 1 for each pixel
    assign plane   = (mode == MODE_2BPP) && bit_cnt[0];
    assign bit_req = active && !busy && !word_pending;

    always_comb begin
        if (mode != MODE_2BPP) begin
            req_ctx = DCU_CTX_W'(history);
        end else if (!plane) begin
            req_ctx = DCU_CTX_W'(DCU_CTX_2BPP_P0) + DCU_CTX_W'(prev_pix);
        end else begin
            req_ctx = DCU_CTX_W'(DCU_CTX_2BPP_P1) + DCU_CTX_W'({prev_pix, p0_bit});
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bit tracking and output write

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            active       <= 1'b0;
            mode         <= MODE_1BPP;
            busy         <= 1'b0;
            word_pending <= 1'b0;
            bit_cnt      <= '0;
            history      <= '0;
            prev_pix     <= '0;
            p0_bit       <= 1'b0;
            ob_wr        <= 1'b0;
        end else if (dcu_init) begin
            active       <= dcu_init_mode != MODE_4BPP;
            mode         <= dcu_init_mode;
            busy         <= 1'b0;
            word_pending <= 1'b0;
            bit_cnt      <= '0;
            history      <= '0;
            prev_pix     <= '0;
            p0_bit       <= 1'b0;
            ob_wr        <= 1'b0;
        end else begin
            ob_wr <= 1'b0;
            if (bit_req) begin
                busy <= 1'b1;
            end
            if (bit_done) begin
                busy    <= 1'b0;
                bit_cnt <= bit_cnt + 1'b1;
                history <= {history[2:0], bit_val};
                if (plane) begin
                    prev_pix <= {bit_val, p0_bit};
                end else begin
                    p0_bit <= bit_val;
                end
                if (bit_cnt == '1) begin
                    word_pending <= 1'b1;
                end
            end else if (word_pending && !ob_wait) begin
                word_pending <= 1'b0;
                ob_wr        <= 1'b1;
            end
        end
    end

    // Plane 0 fills the high half in 2BPP, first pixel lands highest
    always_ff @(posedge CLK) begin
        if (bit_done) begin
            if (mode != MODE_2BPP) begin
                planes <= {planes[DCU_WORD_W-2:0], bit_val};
            end else if (!plane) begin
                planes[DCU_WORD_W-1:DCU_WORD_W/2] <=
                    {planes[DCU_WORD_W-2:DCU_WORD_W/2], bit_val};
            end else begin
                planes[DCU_WORD_W/2-1:0] <= {planes[DCU_WORD_W/2-2:0], bit_val};
            end
        end
        if (word_pending && !ob_wait) begin
            ob_data <= planes;
        end
    end

endmodule

//--- hdl/dcu_pkg.sv
package dcu_pkg;

    // Table and context sizing
    localparam int DCU_NUM_MODELS = 53;
    localparam int DCU_NUM_CTX    = 28;
    localparam int DCU_CTX_W      = 5;
    localparam int DCU_MODEL_W    = 6;

    // Arithmetic decoder range
    localparam int DCU_RANGE_W    = 9;
    localparam int DCU_RANGE_INIT = 256;
    localparam int DCU_RANGE_HALF = 128;

    // Output word and 2BPP context bases
    localparam int DCU_WORD_W      = 32;
    localparam int DCU_CTX_2BPP_P0 = 16;
    localparam int DCU_CTX_2BPP_P1 = 20;

    typedef enum logic [1:0] {
        MODE_1BPP = 2'd0,
        MODE_2BPP = 2'd1,
        MODE_4BPP = 2'd2
    } dcu_mode_e;

    typedef enum logic [1:0] {
        IDLE,
        DECODE,
        RENORM,
        DONE
    } dcu_dec_state_e;

    typedef struct packed {
        logic [7:0]             prob;
        logic [DCU_MODEL_W-1:0] next_lps;
        logic [DCU_MODEL_W-1:0] next_mps;
        logic                   invert;
    } dcu_prob_entry_t;

    typedef struct packed {
        logic [DCU_MODEL_W-1:0] model;
        logic                   swap;
    } dcu_ctx_t;

endpackage

//--- hdl/dcu_prob_table.sv
module dcu_prob_table (
    input  logic [dcu_pkg::DCU_MODEL_W-1:0] model,
    output dcu_pkg::dcu_prob_entry_t        entry
);
    import dcu_pkg::*;

    // Row is {prob, next_lps, next_mps, invert}
    always_comb begin
        entry = '0;
        if (int'(model) < DCU_NUM_MODELS) begin
            case (model)
                // Fast-adapting start group
                6'd0:  entry = '{8'h5a, 6'd1,  6'd1,  1'b1};
                6'd1:  entry = '{8'h25, 6'd6,  6'd2,  1'b0};
                6'd2:  entry = '{8'h11, 6'd8,  6'd3,  1'b0};
                6'd3:  entry = '{8'h08, 6'd10, 6'd4,  1'b0};
                6'd4:  entry = '{8'h03, 6'd12, 6'd5,  1'b0};
                6'd5:  entry = '{8'h01, 6'd15, 6'd5,  1'b0};

                6'd6:  entry = '{8'h5a, 6'd7,  6'd7,  1'b1};
                6'd7:  entry = '{8'h3f, 6'd19, 6'd8,  1'b0};
                6'd8:  entry = '{8'h2c, 6'd21, 6'd9,  1'b0};
                6'd9:  entry = '{8'h20, 6'd22, 6'd10, 1'b0};
                6'd10: entry = '{8'h17, 6'd23, 6'd11, 1'b0};
                6'd11: entry = '{8'h11, 6'd25, 6'd12, 1'b0};
                6'd12: entry = '{8'h0c, 6'd26, 6'd13, 1'b0};
                6'd13: entry = '{8'h09, 6'd28, 6'd14, 1'b0};
                6'd14: entry = '{8'h07, 6'd29, 6'd15, 1'b0};
                6'd15: entry = '{8'h05, 6'd31, 6'd16, 1'b0};
                6'd16: entry = '{8'h04, 6'd32, 6'd17, 1'b0};
                6'd17: entry = '{8'h03, 6'd34, 6'd18, 1'b0};
                6'd18: entry = '{8'h02, 6'd35, 6'd5,  1'b0};

                6'd19: entry = '{8'h5a, 6'd20, 6'd20, 1'b1};
                6'd20: entry = '{8'h48, 6'd39, 6'd21, 1'b0};
                6'd21: entry = '{8'h3a, 6'd40, 6'd22, 1'b0};
                6'd22: entry = '{8'h2e, 6'd42, 6'd23, 1'b0};
                6'd23: entry = '{8'h26, 6'd44, 6'd24, 1'b0};
                6'd24: entry = '{8'h1f, 6'd45, 6'd25, 1'b0};
                6'd25: entry = '{8'h19, 6'd46, 6'd26, 1'b0};
                6'd26: entry = '{8'h15, 6'd25, 6'd27, 1'b0};
                6'd27: entry = '{8'h11, 6'd26, 6'd28, 1'b0};
                6'd28: entry = '{8'h0e, 6'd26, 6'd29, 1'b0};
                6'd29: entry = '{8'h0b, 6'd27, 6'd30, 1'b0};
                6'd30: entry = '{8'h09, 6'd28, 6'd31, 1'b0};
                6'd31: entry = '{8'h08, 6'd29, 6'd32, 1'b0};
                6'd32: entry = '{8'h07, 6'd30, 6'd33, 1'b0};
                6'd33: entry = '{8'h05, 6'd31, 6'd34, 1'b0};
                6'd34: entry = '{8'h04, 6'd33, 6'd35, 1'b0};
                6'd35: entry = '{8'h04, 6'd33, 6'd36, 1'b0};
                6'd36: entry = '{8'h03, 6'd34, 6'd37, 1'b0};
                6'd37: entry = '{8'h02, 6'd35, 6'd38, 1'b0};
                6'd38: entry = '{8'h02, 6'd36, 6'd5,  1'b0};

                // Slow groups, stay near even odds
                6'd39: entry = '{8'h58, 6'd39, 6'd40, 1'b1};
                6'd40: entry = '{8'h4d, 6'd47, 6'd41, 1'b0};
                6'd41: entry = '{8'h43, 6'd48, 6'd42, 1'b0};
                6'd42: entry = '{8'h3b, 6'd49, 6'd43, 1'b0};
                6'd43: entry = '{8'h34, 6'd50, 6'd44, 1'b0};
                6'd44: entry = '{8'h2e, 6'd51, 6'd45, 1'b0};
                6'd45: entry = '{8'h29, 6'd44, 6'd46, 1'b0};
                6'd46: entry = '{8'h25, 6'd45, 6'd24, 1'b0};

                6'd47: entry = '{8'h56, 6'd47, 6'd48, 1'b1};
                6'd48: entry = '{8'h4f, 6'd47, 6'd49, 1'b0};
                6'd49: entry = '{8'h47, 6'd48, 6'd50, 1'b0};
                6'd50: entry = '{8'h41, 6'd49, 6'd51, 1'b0};
                6'd51: entry = '{8'h3c, 6'd50, 6'd52, 1'b0};
                6'd52: entry = '{8'h37, 6'd51, 6'd43, 1'b0};
            endcase
        end
    end

endmodule

//--- hdl/dcu_rom_fetch.sv
module dcu_rom_fetch (
    input  logic               CLK,
    input  logic               rst_n,
    input  logic               dcu_init,
    input  dcu_pkg::dcu_mode_e dcu_init_mode,
    input  logic               datarom_wait,
    input  logic [7:0]         datarom_data,
    input  logic               fetch_take,
    output logic               datarom_rd,
    output logic [7:0]         fetch_byte,
    output logic               fetch_valid,
    output logic               preread_done
);
    import dcu_pkg::*;

    logic       active;
    logic [1:0] count;
    logic [7:0] slot [2];
    logic       accept;
    logic       take;
    logic       wr_idx;
    logic [1:0] count_next;

    assign accept      = datarom_rd && !datarom_wait;
    assign take        = fetch_take && fetch_valid;
    assign count_next  = count + 2'(accept) - 2'(take);
    assign wr_idx      = count[0] & ~take;
    assign fetch_valid = count != 2'd0;
    assign fetch_byte  = slot[0];

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            active       <= 1'b0;
            count        <= 2'd0;
            datarom_rd   <= 1'b0;
            preread_done <= 1'b0;
        end else if (dcu_init) begin
            // Buffer flushed, 4BPP leaves the port idle
            active       <= dcu_init_mode != MODE_4BPP;
            count        <= 2'd0;
            datarom_rd   <= dcu_init_mode != MODE_4BPP;
            preread_done <= 1'b0;
        end else begin
            count      <= count_next;
            datarom_rd <= active && count_next != 2'd2;
            if (active && count_next == 2'd2) begin
                preread_done <= 1'b1;
            end
        end
    end

    // Slot 0 is the head, slot 1 moves up on a take
    always_ff @(posedge CLK) begin
        if (take) begin
            slot[0] <= slot[1];
        end
        if (accept) begin
            slot[wr_idx] <= datarom_data;
        end
    end

endmodule

//--- hdl/spc7110_dcu.sv
module spc7110_dcu (
    input  logic                           CLK,
    input  logic                           rst_n,
    input  logic                           dcu_init,
    input  dcu_pkg::dcu_mode_e             dcu_init_mode,
    input  logic                           datarom_wait,
    output logic                           datarom_rd,
    input  logic [7:0]                     datarom_data,
    input  logic                           ob_wait,
    output logic                           ob_wr,
    output logic [dcu_pkg::DCU_WORD_W-1:0] ob_data
);
    import dcu_pkg::*;

    // Fetch to decoder
    logic [7:0]           fetch_byte;
    logic                 fetch_valid;
    logic                 fetch_take;
    logic                 preread_done;

    // Packer to decoder bit requests
    logic                 bit_req;
    logic [DCU_CTX_W-1:0] req_ctx;
    logic                 bit_done;
    logic                 bit_val;

    dcu_rom_fetch u_rom_fetch (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .dcu_init      (dcu_init),
        .dcu_init_mode (dcu_init_mode),
        .datarom_wait  (datarom_wait),
        .datarom_data  (datarom_data),
        .fetch_take    (fetch_take),
        .datarom_rd    (datarom_rd),
        .fetch_byte    (fetch_byte),
        .fetch_valid   (fetch_valid),
        .preread_done  (preread_done)
    );

    dcu_bit_decoder u_bit_decoder (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .dcu_init      (dcu_init),
        .dcu_init_mode (dcu_init_mode),
        .bit_req       (bit_req),
        .req_ctx       (req_ctx),
        .fetch_byte    (fetch_byte),
        .fetch_valid   (fetch_valid),
        .preread_done  (preread_done),
        .fetch_take    (fetch_take),
        .bit_done      (bit_done),
        .bit_val       (bit_val)
    );

    dcu_pixel_packer u_pixel_packer (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .dcu_init      (dcu_init),
        .dcu_init_mode (dcu_init_mode),
        .bit_done      (bit_done),
        .bit_val       (bit_val),
        .ob_wait       (ob_wait),
        .bit_req       (bit_req),
        .req_ctx       (req_ctx),
        .ob_wr         (ob_wr),
        .ob_data       (ob_data)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run; the exit status carries pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f spc7110_dcu.f --top-module tb_spc7110_dcu \
    -o tb_spc7110_dcu && ./obj_dir/tb_spc7110_dcu || exit 1

//--- spc7110_dcu.f
+incdir+tests
hdl/dcu_pkg.sv
hdl/dcu_prob_table.sv
hdl/dcu_rom_fetch.sv
hdl/dcu_bit_decoder.sv
hdl/dcu_pixel_packer.sv
hdl/spc7110_dcu.sv
tests/spc7110_dcu_checker.sv
tests/tb_spc7110_dcu.sv

//--- tests/dcu_patterns.txt
// mode rom_stall% ob_stall% words abort_after nbytes, then the compressed bytes (hex)
// mode 00 is 1BPP, 01 2BPP, 02 4BPP; abort_after 00 runs all words; ff ends the list
00 00 00 04 00 10
3c a5 19 e2 7f 04 b8 51 c6 2d 93 0e 6a f1 48 d7
01 00 00 04 00 10
e9 12 77 c0 5b 3a 8d 41 f6 29 0c b3 64 9e d5 18
00 00 32 04 00 0c
81 4e 27 fa 93 6c 05 d2 b7 3f 58 a0
01 00 32 04 00 0c
2a 9f 63 d8 17 c4 70 eb 35 8e 41 bc
00 32 00 04 00 0c
f0 0f 55 aa 12 34 56 78 9a bc de 02
01 32 28 05 00 10
6d 93 b1 0e 47 f8 2c d5 a6 19 73 ee 08 c1 5a 34
00 14 14 06 02 10
c7 38 9b 64 21 de 80 7f 4c b3 15 ea 96 69 0d f2
01 00 00 04 00 08
ab cd ef 01 23 45 67 89
02 00 00 00 00 00
01 28 28 04 00 0c
11 22 33 44 55 66 77 88 99 aa bb cc
ff

//--- tests/spc7110_dcu_checker.sv
module spc7110_dcu_checker (
    input logic CLK,
    input logic rst_n,
    input logic dcu_init,
    input logic datarom_rd,
    input logic datarom_wait,
    input logic ob_wait,
    input logic ob_wr
);
    timeunit 1ns;
    timeprecision 1ps;

    // Write only follows an edge with the buffer ready
    a_ob_wr_after_ready: assert property (@(posedge CLK) disable iff (!rst_n)
        ob_wr |-> !$past(ob_wait))
        else $error("ob_wr after an edge where ob_wait was high");

    // Read request holds through ROM wait states
    a_rd_held: assert property (@(posedge CLK) disable iff (!rst_n)
        (datarom_rd && datarom_wait && !dcu_init) |=> datarom_rd)
        else $error("datarom_rd dropped while datarom_wait was high");

    a_ob_wr_single: assert property (@(posedge CLK) disable iff (!rst_n)
        ob_wr |=> !ob_wr)
        else $error("ob_wr high for two cycles in a row");

endmodule

bind spc7110_dcu spc7110_dcu_checker u_checker (.*);

//--- tests/dcu_ref_model.svh
// Probability states, one entry per model index
int ref_prob [53] = '{
    'h5a, 'h25, 'h11, 'h08, 'h03, 'h01, 'h5a, 'h3f, 'h2c, 'h20, 'h17, 'h11, 'h0c,
    'h09, 'h07, 'h05, 'h04, 'h03, 'h02, 'h5a, 'h48, 'h3a, 'h2e, 'h26, 'h1f, 'h19,
    'h15, 'h11, 'h0e, 'h0b, 'h09, 'h08, 'h07, 'h05, 'h04, 'h04, 'h03, 'h02, 'h02,
    'h58, 'h4d, 'h43, 'h3b, 'h34, 'h2e, 'h29, 'h25, 'h56, 'h4f, 'h47, 'h41, 'h3c, 'h37};
int ref_next_lps [53] = '{
    1, 6, 8, 10, 12, 15, 7, 19, 21, 22, 23, 25, 26, 28, 29, 31, 32, 34, 35,
    20, 39, 40, 42, 44, 45, 46, 25, 26, 26, 27, 28, 29, 30, 31, 33, 33, 34, 35, 36,
    39, 47, 48, 49, 50, 51, 44, 45, 47, 47, 48, 49, 50, 51};
int ref_next_mps [53] = '{
    1, 2, 3, 4, 5, 5, 7, 8, 9, 10, 11, 12, 13, 14, 15, 16, 17, 18, 5,
    20, 21, 22, 23, 24, 25, 26, 27, 28, 29, 30, 31, 32, 33, 34, 35, 36, 37, 38, 5,
    40, 41, 42, 43, 44, 45, 46, 24, 48, 49, 50, 51, 52, 43};

function automatic bit ref_invert(input int m);
    return m == 0 || m == 6 || m == 19 || m == 39 || m == 47;
endfunction

// Decodes the current case bytes into the expected word queue
function automatic void ref_decode(input int mode, input int nwords);
    int          mdl [28];
    bit          swp [28];
    int          range_r;
    int          win;
    int          pos;
    int          shifts;
    int          ctx;
    int          m;
    int          off;
    int          sym;
    int          bitv;
    int          hist;
    int          prev;
    int          p0;
    logic [31:0] word;
    for (int i = 0; i < 28; i++) begin
        mdl[i] = 0;
        swp[i] = 1'b0;
    end
    range_r = 256;
    win = (int'(rom_byte(0)) << 8) | int'(rom_byte(1));
    pos = 2;
    shifts = 0;
    hist = 0;
    prev = 0;
    p0 = 0;
    for (int w = 0; w < nwords; w++) begin
        word = '0;
        for (int n = 0; n < 32; n++) begin
            if (mode == 0) begin
                ctx = hist;
            end else if (n % 2 == 0) begin
                ctx = 16 + prev;
            end else begin
                ctx = 20 + 2 * prev + p0;
            end
            m = mdl[ctx];
            off = range_r - ref_prob[m];
            if ((win >> 8) < off) begin
                sym = 0;
                range_r = off;
            end else begin
                sym = 1;
                range_r = range_r - off;
                win = win - (off << 8);
            end
            bitv = sym ^ int'(swp[ctx]);
            if (range_r < 128) begin
                if (sym == 0) begin
                    mdl[ctx] = ref_next_mps[m];
                end else begin
                    mdl[ctx] = ref_next_lps[m];
                    swp[ctx] = swp[ctx] ^ ref_invert(m);
                end
            end
            while (range_r < 128) begin
                range_r = range_r << 1;
                win = (win << 1) & 'hffff;
                shifts++;
                if (shifts == 8) begin
                    shifts = 0;
                    win = (win & 'hff00) | int'(rom_byte(pos));
                    pos++;
                end
            end
            hist = ((hist << 1) | bitv) & 15;
            if (mode == 0) begin
                word[31-n] = 1'(bitv);
            end else if (n % 2 == 0) begin
                word[31-n/2] = 1'(bitv);
                p0 = bitv;
            end else begin
                word[15-n/2] = 1'(bitv);
                prev = 2 * bitv + p0;
            end
        end
        exp_words.push_back(word);
    end
endfunction

//--- tests/tb_spc7110_dcu.sv
module tb_spc7110_dcu;
    timeunit 1ns;
    timeprecision 1ps;
    import dcu_pkg::*;

    localparam int BIT_CYCLES = 80;

    logic        CLK;
    logic        rst_n;
    logic        dcu_init;
    dcu_mode_e   dcu_init_mode;
    logic        datarom_wait;
    logic        datarom_rd;
    logic [7:0]  datarom_data;
    logic        ob_wait;
    logic        ob_wr;
    logic [31:0] ob_data;

    logic [7:0]  pat_mem [0:1023];
    logic [7:0]  case_bytes [$];
    logic [31:0] exp_words [$];
    int          rom_idx;
    int          rom_stall;
    int          ob_stall;
    int          words_seen;
    longint      timeout_ns;
    bit          watchdog_armed;

    spc7110_dcu dut (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .dcu_init      (dcu_init),
        .dcu_init_mode (dcu_init_mode),
        .datarom_wait  (datarom_wait),
        .datarom_rd    (datarom_rd),
        .datarom_data  (datarom_data),
        .ob_wait       (ob_wait),
        .ob_wr         (ob_wr),
        .ob_data       (ob_data)
    );

    always #50 CLK = ~CLK;

    // ROM contents past the end of the stream read as zero
    function automatic logic [7:0] rom_byte(input int i);
        if (i < case_bytes.size()) begin
            return case_bytes[i];
        end
        return 8'h00;
    endfunction

    `include "dcu_ref_model.svh"

    task automatic stop_with_failure(input string reason);
        $display("Done: errors found");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input string what, input logic [31:0] got_v,
                               input logic [31:0] exp_v);
        if (got_v !== exp_v) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got_v, exp_v);
            stop_with_failure("value mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Each falling edge collects a word and then drives ROM and buffer inputs

    task automatic drive_cycle(input bit init_now, input int mode);
        if (ob_wr) begin
            if (exp_words.size() == 0) begin
                stop_with_failure("output word written when none was expected");
            end
            check_value("ob_data", ob_data, exp_words.pop_front());
            words_seen++;
        end
        datarom_wait = ($urandom % 100) < rom_stall;
        if (init_now) begin
            dcu_init      = 1'b1;
            dcu_init_mode = dcu_mode_e'(2'(mode));
            rom_idx       = 0;
            datarom_data  = rom_byte(0);
        end else begin
            dcu_init     = 1'b0;
            datarom_data = rom_byte(rom_idx);
            // Byte is taken at the coming rising edge
            if (datarom_rd && !datarom_wait) begin
                rom_idx++;
            end
        end
        ob_wait = ($urandom % 100) < ob_stall;
    endtask

    task automatic run_case(input int ptr, output int next_ptr);
        int mode;
        int nwords;
        int abort_after;
        int nbytes;
        int target;
        mode        = int'(pat_mem[ptr]);
        rom_stall   = int'(pat_mem[ptr+1]);
        ob_stall    = int'(pat_mem[ptr+2]);
        nwords      = int'(pat_mem[ptr+3]);
        abort_after = int'(pat_mem[ptr+4]);
        nbytes      = int'(pat_mem[ptr+5]);
        case_bytes.delete();
        for (int i = 0; i < nbytes; i++) begin
            case_bytes.push_back(pat_mem[ptr+6+i]);
        end
        next_ptr = ptr + 6 + nbytes;
        exp_words.delete();
        if (mode != 2) begin
            ref_decode(mode, nwords);
        end
        words_seen = 0;
        @(negedge CLK);
        drive_cycle(1'b1, mode);
        if (mode == 2) begin
            repeat (30) begin
                @(negedge CLK);
                drive_cycle(1'b0, mode);
                check_value("datarom_rd after 4BPP init", 32'(datarom_rd), 32'd0);
                check_value("ob_wr after 4BPP init", 32'(ob_wr), 32'd0);
            end
        end else begin
            target = (abort_after != 0) ? abort_after : nwords;
            while (words_seen < target) begin
                @(negedge CLK);
                drive_cycle(1'b0, mode);
            end
        end
    endtask

    initial begin
        int ptr;
        int nxt;
        int total_words;
        int total_bytes;
        void'($urandom(32'h675));
        CLK            = 1'b0;
        rst_n          = 1'b0;
        dcu_init       = 1'b0;
        dcu_init_mode  = MODE_1BPP;
        datarom_wait   = 1'b0;
        datarom_data   = 8'h00;
        ob_wait        = 1'b0;
        rom_idx        = 0;
        rom_stall      = 0;
        ob_stall       = 0;
        words_seen     = 0;
        watchdog_armed = 1'b0;
        $readmemh("tests/dcu_patterns.txt", pat_mem);
        if (pat_mem[0] === 8'hxx) begin
            stop_with_failure("pattern file could not be read");
        end

        // Size the watchdog from the whole pattern list
        total_words = 0;
        total_bytes = 0;
        ptr = 0;
        while (pat_mem[ptr] != 8'hff) begin
            total_words += int'(pat_mem[ptr+3]);
            total_bytes += int'(pat_mem[ptr+5]);
            ptr += 6 + int'(pat_mem[ptr+5]);
        end
        timeout_ns = longint'(total_words * 32 * BIT_CYCLES + total_bytes * BIT_CYCLES + 2000)
                     * 100;
        watchdog_armed = 1'b1;

        repeat (5) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;

        // Ports stay idle after reset until the first init
        repeat (10) begin
            @(negedge CLK);
            drive_cycle(1'b0, 0);
            check_value("datarom_rd before init", 32'(datarom_rd), 32'd0);
            check_value("ob_wr before init", 32'(ob_wr), 32'd0);
        end

        ptr = 0;
        while (pat_mem[ptr] != 8'hff) begin
            run_case(ptr, nxt);
            ptr = nxt;
        end
        $display("Done: no errors");
        $finish;
    end

    initial begin
        wait (watchdog_armed);
        #(timeout_ns);
        stop_with_failure("timeout, the DUT stopped producing output words");
    end

endmodule
